// File: tb.f
+incdir+src
src/pe_pkg.sv
src/compressed_spad.sv
src/col_ptr_spad.sv
src/psum_spad.sv
src/mac_sequencer.sv
src/psum_drain.sv
src/pe_top.sv
verif/pe_asserts.sv
verif/pe_tb.sv

// File: verif/pe_tb.sv
// testbench for the processing element core
// loads four table cases, runs the sparse mac, then drains the
// partial sums twice and compares against a reference model
`timescale 1ns/1ns
`default_nettype none

`include "pe_defs.svh"

module pe_tb;

	localparam int MAC_TIMEOUT   = 2000;   // cycles
	localparam int DRAIN_TIMEOUT = 200;

	logic                        clock;
	logic                        reset;
	logic                        load_en;
	logic                        mac_en;
	logic                        cal_fin;
	logic                        psum_clear;
	logic                        psum_enq_en;
	logic                        psum_in_valid;
	pe_pkg::psum_t               psum_in;
	logic                        psum_in_ready;
	logic                        psum_out_ready;
	logic                        psum_out_valid;
	pe_pkg::psum_t               psum_out;
	logic                        psum_acc_fin;
	logic                        iact_data_in_valid;
	logic [`IACT_ENTRY_W-1:0]    iact_data_in;
	logic                        iact_data_write_fin;
	logic                        weight_ptr_in_valid;
	logic [`PTR_W-1:0]           weight_ptr_in;
	logic                        weight_ptr_write_fin;
	logic                        weight_data_in_valid;
	logic [`WEIGHT_ENTRY_W-1:0]  weight_data_in;
	logic                        weight_data_write_fin;

	// case table, a zero value ends the activation and weight lists
	int iact_val [4][5] = '{'{5, -3, 2, 9, 0}, '{-7, 4, 0, 0, 0},
		'{-128, 127, 1, 0, 0}, '{100, -100, 0, 0, 0}};
	int iact_col [4][5] = '{'{0, 2, 1, 3, 0}, '{3, 0, 0, 0, 0},
		'{30, 31, 5, 0, 0}, '{30, 31, 0, 0, 0}};
	int wgt_val [4][7] = '{'{3, -2, 4, 7, -5, 1, 0}, '{3, -2, 4, 7, -5, 1, 0},
		'{127, -128, 50, -1, 0, 0, 0}, '{127, -128, 50, -1, 0, 0, 0}};
	int wgt_row [4][7] = '{'{0, 5, 15, 1, 14, 9, 0}, '{0, 5, 15, 1, 14, 9, 0},
		'{2, 2, 15, 12, 0, 0, 0}, '{2, 2, 15, 12, 0, 0, 0}};
	int col_ptr [4][32] = '{
		'{2, 2, 5, 6, 6, 6, 6, 6, 6, 6, 6, 6, 6, 6, 6, 6,
		  6, 6, 6, 6, 6, 6, 6, 6, 6, 6, 6, 6, 6, 6, 6, 6},
		'{2, 2, 5, 6, 6, 6, 6, 6, 6, 6, 6, 6, 6, 6, 6, 6,
		  6, 6, 6, 6, 6, 6, 6, 6, 6, 6, 6, 6, 6, 6, 6, 6},
		'{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0,
		  0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 3, 4},
		'{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0,
		  0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 3, 4}};
	bit do_clear [4] = '{1, 0, 1, 0};   // cases 1 and 3 accumulate

	pe_pkg::psum_t model [`PSUM_DEPTH];
	int            seed = 32'h5ba6e610;
	int            errors;
	int            checks;
	bit            timed_out;

	pe_top i_pe_top (.*);

	initial clock = 1'b0;
	always #50 clock = ~clock;

	task automatic next_cycle();
		@(posedge clock);
		#5;   // drive point
	endtask

	task automatic check(input bit ok, input string msg);
		checks++;
		assert (ok) else begin
			$display("** Error at %0t ns: %s", $time, msg);
			errors++;
		end
	endtask

	function automatic logic fin_of(input int which);
		if (which == 0)
			return iact_data_write_fin;
		else if (which == 1)
			return weight_ptr_write_fin;
		return weight_data_write_fin;
	endfunction

	// psum[row] += a * w over the column of each activation, pad row skipped
	task automatic model_mac(input int c);
		int k;
		int lo;
		int hi;
		for (int i = 0; i < 5 && iact_val[c][i] != 0; i++) begin
			k  = iact_col[c][i];
			lo = (k == 0) ? 0 : col_ptr[c][k-1];
			hi = col_ptr[c][k];
			for (int j = lo; j < hi; j++)
				if (wgt_row[c][j] != `PAD_ROW)
					model[wgt_row[c][j]] = model[wgt_row[c][j]]
						+ pe_pkg::psum_t'(iact_val[c][i] * wgt_val[c][j]);
		end
	endtask

	// one scratchpad, beat by beat, write_fin only after the last one
	task automatic load_spad(input int which, input int c);
		logic fin;
		bit   last;
		int   i;
		i    = 0;
		last = 1'b0;
		while (!last) begin
			case (which)
				0: begin
					iact_data_in_valid = 1'b1;
					iact_data_in       = {8'(iact_val[c][i]), 5'(iact_col[c][i])};
					last               = (iact_val[c][i] == 0);
				end
				1: begin
					weight_ptr_in_valid = 1'b1;
					weight_ptr_in       = 7'(col_ptr[c][i]);
					last                = (i == `COL_COUNT - 1);
				end
				default: begin
					weight_data_in_valid = 1'b1;
					weight_data_in       = {8'(wgt_val[c][i]), 4'(wgt_row[c][i])};
					last                 = (wgt_val[c][i] == 0);
				end
			endcase
			next_cycle();
			fin = fin_of(which);
			check(fin == last, $sformatf("spad %0d write_fin %0b after beat %0d", which, fin, i));
			i++;
		end
		iact_data_in_valid   = 1'b0;
		weight_ptr_in_valid  = 1'b0;
		weight_data_in_valid = 1'b0;
		next_cycle();
		check(!fin_of(which), $sformatf("spad %0d write_fin longer than one cycle", which));
	endtask

	task automatic run_mac(input int c);
		int n;
		mac_en = 1'b1;
		next_cycle();
		mac_en = 1'b0;
		n      = 0;
		while (!cal_fin && n < MAC_TIMEOUT) begin
			next_cycle();
			n++;
		end
		if (!cal_fin) begin
			$display("timeout: cal_fin never arrived in case %0d", c);
			timed_out = 1'b1;
		end else begin
			model_mac(c);
			next_cycle();
			check(!cal_fin, "cal_fin longer than one cycle");
		end
	endtask

	// random_mode adds random psum_in and random back-pressure
	task automatic drain_check(input int c, input bit random_mode);
		pe_pkg::psum_t pin;
		pe_pkg::psum_t expect_val;
		int            idx;
		int            n;
		psum_enq_en = 1'b1;
		next_cycle();
		psum_enq_en   = 1'b0;
		psum_in_valid = 1'b1;
		idx           = 0;
		n             = 0;
		while (idx < `PSUM_DEPTH && n < DRAIN_TIMEOUT) begin
			pin            = random_mode ? pe_pkg::psum_t'($random(seed)) : '0;
			psum_in        = pin;
			psum_out_ready = random_mode ? (($random(seed) & 3) != 0) : 1'b1;
			#45;   // mid cycle, outputs settled
			check(psum_in_ready == psum_out_ready, "psum_in_ready does not follow psum_out_ready");
			if (psum_out_ready) begin
				expect_val = model[idx] + pin;
				check(psum_out_valid && psum_out == expect_val,
					$sformatf("psum_out[%0d] = %0d, expected %0d", idx, psum_out, expect_val));
				check(psum_acc_fin == (idx == `PSUM_DEPTH - 1),
					$sformatf("psum_acc_fin %0b at transfer %0d", psum_acc_fin, idx));
				idx++;
			end else begin
				check(!psum_acc_fin, "psum_acc_fin while stalled");
			end
			next_cycle();
			n++;
		end
		if (idx < `PSUM_DEPTH) begin
			$display("timeout: drain stopped at index %0d in case %0d", idx, c);
			timed_out = 1'b1;
		end else begin
			check(!psum_out_valid && !psum_in_ready, "drain mode did not end");
		end
		psum_in_valid  = 1'b0;
		psum_out_ready = 1'b0;
	endtask

	initial begin
		int errors_before;
		reset                = 1'b1;
		load_en              = 1'b0;
		mac_en               = 1'b0;
		psum_clear           = 1'b0;
		psum_enq_en          = 1'b0;
		psum_in_valid        = 1'b0;
		psum_in              = '0;
		psum_out_ready       = 1'b0;
		iact_data_in_valid   = 1'b0;
		iact_data_in         = '0;
		weight_ptr_in_valid  = 1'b0;
		weight_ptr_in        = '0;
		weight_data_in_valid = 1'b0;
		weight_data_in       = '0;
		repeat (4) next_cycle();
		reset = 1'b0;
		for (int i = 0; i < `PSUM_DEPTH; i++)
			model[i] = '0;
		for (int c = 0; c < 4 && !timed_out; c++) begin
			errors_before = errors;
			load_en       = 1'b1;
			load_spad(0, c);
			load_spad(1, c);
			load_spad(2, c);
			load_en = 1'b0;
			if (do_clear[c]) begin
				psum_clear = 1'b1;
				next_cycle();
				psum_clear = 1'b0;
				for (int i = 0; i < `PSUM_DEPTH; i++)
					model[i] = '0;
			end
			run_mac(c);
			if (!timed_out)
				drain_check(c, 1'b0);
			if (!timed_out)
				drain_check(c, 1'b1);
			$display("case %0d finished with %0d errors", c, errors - errors_before);
		end
		$display("%0d checks, %0d errors, timeout %0b", checks, errors, timed_out);
		if (errors == 0 && !timed_out)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/pe_asserts.sv
// protocol checks on the processing element core
// pulse widths, drain-mode ready and compute/drain overlap
`timescale 1ns/1ns
`default_nettype none

`include "pe_defs.svh"

module pe_asserts (
	input wire clock,
	input wire reset,
	input wire mac_en,
	input wire cal_fin,
	input wire psum_enq_en,
	input wire psum_in_valid,
	input wire psum_in_ready,
	input wire psum_out_ready,
	input wire psum_acc_fin
);

	logic       in_drain;     // drain mode rebuilt from enq and transfers
	logic [3:0] xfer_count;
	logic       xfer;

	assign xfer = in_drain && psum_in_valid && psum_out_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			in_drain   <= 1'b0;
			xfer_count <= '0;
		end else if (psum_enq_en) begin
			in_drain   <= 1'b1;
			xfer_count <= '0;
		end else if (xfer) begin
			xfer_count <= xfer_count + 1'b1;
			if (xfer_count == 4'(`PSUM_DEPTH - 1))
				in_drain <= 1'b0;   // 16th transfer
		end
	end

	cal_fin_pulse: assert property (@(posedge clock) disable iff (reset)
		cal_fin |=> !cal_fin)
		else $error("cal_fin high for more than one cycle");

	acc_fin_pulse: assert property (@(posedge clock) disable iff (reset)
		psum_acc_fin |=> !psum_acc_fin)
		else $error("psum_acc_fin high for more than one cycle");

	ready_in_drain: assert property (@(posedge clock) disable iff (reset)
		psum_in_ready |-> in_drain)
		else $error("psum_in_ready high outside drain mode");

	no_mac_in_drain: assert property (@(posedge clock) disable iff (reset)
		!(mac_en && in_drain))
		else $error("mac_en raised during a drain");

endmodule

bind pe_top pe_asserts i_pe_asserts (.clock, .reset, .mac_en, .cal_fin,
	.psum_enq_en, .psum_in_valid, .psum_in_ready, .psum_out_ready, .psum_acc_fin);

`default_nettype wire

// File: src/pe_top.sv
// processing element core
// activation, pointer and weight scratchpads feeding the sparse mac
// sequencer, a partial-sum register file and the drain path
`timescale 1ns/1ns
`default_nettype none

`include "pe_defs.svh"

module pe_top (
	input  wire                          clock,
	input  wire                          reset,
	input  wire                          load_en,
	input  wire                          mac_en,
	output logic                         cal_fin,
	input  wire                          psum_clear,
	input  wire                          psum_enq_en,
	input  wire                          psum_in_valid,
	input  wire pe_pkg::psum_t           psum_in,
	output logic                         psum_in_ready,
	input  wire                          psum_out_ready,
	output logic                         psum_out_valid,
	output pe_pkg::psum_t                psum_out,
	output logic                         psum_acc_fin,
	input  wire                          iact_data_in_valid,
	input  wire  [`IACT_ENTRY_W-1:0]     iact_data_in,
	output logic                         iact_data_write_fin,
	input  wire                          weight_ptr_in_valid,
	input  wire  [`PTR_W-1:0]            weight_ptr_in,
	output logic                         weight_ptr_write_fin,
	input  wire                          weight_data_in_valid,
	input  wire  [`WEIGHT_ENTRY_W-1:0]   weight_data_in,
	output logic                         weight_data_write_fin
);

	logic [`PTR_W-1:0]           iact_read_idx;
	logic [`IACT_ENTRY_W-1:0]    iact_entry;
	logic [`IACT_COL_W-1:0]      ptr_col;
	logic [`PTR_W-1:0]           col_start;
	logic [`PTR_W-1:0]           col_end;
	logic [`PTR_W-1:0]           weight_read_idx;
	logic [`WEIGHT_ENTRY_W-1:0]  weight_entry;
	pe_pkg::psum_idx_t           psum_acc_idx;
	pe_pkg::psum_t               psum_acc_data;
	logic                        psum_write_en;
	pe_pkg::psum_t               psum_write_data;
	pe_pkg::psum_idx_t           drain_idx;
	pe_pkg::psum_t               drain_data;

	compressed_spad #(
		.ENTRY_W (`IACT_ENTRY_W),
		.DEPTH   (`IACT_DEPTH)
	) i_iact_spad (
		.clock, .reset, .load_en,
		.data_in_valid (iact_data_in_valid),
		.data_in       (iact_data_in),
		.write_fin     (iact_data_write_fin),
		.read_idx      (iact_read_idx),
		.data_out      (iact_entry)
	);

	col_ptr_spad i_col_ptr_spad (
		.clock, .reset, .load_en,
		.data_in_valid (weight_ptr_in_valid),
		.data_in       (weight_ptr_in),
		.write_fin     (weight_ptr_write_fin),
		.col           (ptr_col),
		.col_start, .col_end
	);

	compressed_spad #(
		.ENTRY_W (`WEIGHT_ENTRY_W),
		.DEPTH   (`WEIGHT_DEPTH)
	) i_weight_spad (
		.clock, .reset, .load_en,
		.data_in_valid (weight_data_in_valid),
		.data_in       (weight_data_in),
		.write_fin     (weight_data_write_fin),
		.read_idx      (weight_read_idx),
		.data_out      (weight_entry)
	);

	psum_spad i_psum_spad (
		.clock, .reset,
		.clear      (psum_clear),
		.write_en   (psum_write_en),
		.write_idx  (psum_acc_idx),   // sequencer writes where it read
		.write_data (psum_write_data),
		.acc_idx    (psum_acc_idx),
		.acc_data   (psum_acc_data),
		.drain_idx, .drain_data
	);

	mac_sequencer i_mac_sequencer (
		.clock, .reset, .mac_en, .cal_fin,
		.iact_read_idx, .iact_entry,
		.ptr_col, .col_start, .col_end,
		.weight_read_idx, .weight_entry,
		.psum_acc_idx, .psum_acc_data,
		.psum_write_en, .psum_write_data
	);

	psum_drain i_psum_drain (
		.clock, .reset, .psum_enq_en,
		.psum_in_valid, .psum_in, .psum_in_ready,
		.psum_out_ready, .psum_out_valid, .psum_out,
		.psum_acc_fin, .drain_idx, .drain_data
	);

endmodule

`default_nettype wire

// File: src/psum_drain.sv
// partial-sum drain
// streams the 16 partial sums out in index order, each one added to
// the psum_in beat from the neighbor, with zero latency
`timescale 1ns/1ns
`default_nettype none

`include "pe_defs.svh"

module psum_drain (
	input  wire                      clock,
	input  wire                      reset,
	input  wire                      psum_enq_en,
	input  wire                      psum_in_valid,
	input  wire pe_pkg::psum_t       psum_in,
	output logic                     psum_in_ready,
	input  wire                      psum_out_ready,
	output logic                     psum_out_valid,
	output pe_pkg::psum_t            psum_out,
	output logic                     psum_acc_fin,
	output pe_pkg::psum_idx_t        drain_idx,
	input  wire pe_pkg::psum_t       drain_data
);

	logic draining;
	logic xfer;

	assign psum_out_valid = draining && psum_in_valid;
	assign psum_in_ready  = draining && psum_out_ready;
	assign psum_out       = drain_data + psum_in;
	assign xfer           = draining && psum_in_valid && psum_out_ready;
	assign psum_acc_fin   = xfer && (drain_idx == pe_pkg::psum_idx_t'(`PSUM_DEPTH - 1));

	always_ff @(posedge clock) begin
		if (reset) begin
			draining  <= 1'b0;
			drain_idx <= '0;
		end else if (psum_enq_en) begin
			draining  <= 1'b1;
			drain_idx <= '0;
		end else if (xfer) begin
			drain_idx <= drain_idx + 1'b1;   // wraps to 0 after the last entry
			if (psum_acc_fin)
				draining <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: src/mac_sequencer.sv
// sparse mac sequencer
// walks the activation list, looks up the weight column of each
// nonzero activation and accumulates a*w into psum[row],
// one weight entry at a time, three cycles per entry
`timescale 1ns/1ns
`default_nettype none

`include "pe_defs.svh"

module mac_sequencer (
	input  wire                          clock,
	input  wire                          reset,
	input  wire                          mac_en,
	output logic                         cal_fin,
	output logic [`PTR_W-1:0]            iact_read_idx,
	input  wire  [`IACT_ENTRY_W-1:0]     iact_entry,
	output logic [`IACT_COL_W-1:0]       ptr_col,
	input  wire  [`PTR_W-1:0]            col_start,
	input  wire  [`PTR_W-1:0]            col_end,
	output logic [`PTR_W-1:0]            weight_read_idx,
	input  wire  [`WEIGHT_ENTRY_W-1:0]   weight_entry,
	output pe_pkg::psum_idx_t            psum_acc_idx,
	input  wire pe_pkg::psum_t           psum_acc_data,
	output logic                         psum_write_en,
	output pe_pkg::psum_t                psum_write_data
);

	localparam int IACT_AW = $clog2(`IACT_DEPTH);

	pe_pkg::seq_state_e          state;
	logic [IACT_AW-1:0]          iact_idx;
	logic [`IACT_COL_W-1:0]      col_reg;       // column of the held activation
	logic [`PTR_W-1:0]           weight_idx;
	logic signed [`VALUE_W-1:0]  iact_val;
	pe_pkg::psum_t               product_reg;
	pe_pkg::psum_idx_t           row_reg;

	logic signed [`VALUE_W-1:0]  iact_value;
	logic [`IACT_COL_W-1:0]      iact_col;
	logic signed [`VALUE_W-1:0]  weight_value;
	pe_pkg::psum_idx_t           weight_row;

	// entry fields
	assign iact_value   = iact_entry[`IACT_ENTRY_W-1 -: `VALUE_W];
	assign iact_col     = iact_entry[`IACT_COL_W-1:0];
	assign weight_value = weight_entry[`WEIGHT_ENTRY_W-1 -: `VALUE_W];
	assign weight_row   = weight_entry[`WEIGHT_ROW_W-1:0];

	assign iact_read_idx   = {{(`PTR_W - IACT_AW){1'b0}}, iact_idx};
	assign ptr_col         = col_reg;
	assign weight_read_idx = weight_idx;

	// psum is read and written at the same row during WRITE_BACK
	assign psum_acc_idx    = row_reg;
	assign psum_write_en   = (state == pe_pkg::WRITE_BACK);
	assign psum_write_data = psum_acc_data + product_reg;

	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= pe_pkg::IDLE;
			iact_idx   <= '0;
			col_reg    <= '0;
			weight_idx <= '0;
			cal_fin    <= 1'b0;
		end else begin
			cal_fin <= 1'b0;
			case (state)
				pe_pkg::IDLE: begin
					if (mac_en)
						state <= pe_pkg::READ_IACT;
				end
				pe_pkg::READ_IACT: begin
					if (iact_value == '0) begin   // terminator, all activations done
						state    <= pe_pkg::IDLE;
						iact_idx <= '0;
						cal_fin  <= 1'b1;
					end else begin
						state    <= pe_pkg::READ_PTR;
						col_reg  <= iact_col;
						iact_idx <= iact_idx + 1'b1;   // prefetch next activation
					end
				end
				pe_pkg::READ_PTR: begin
					weight_idx <= col_start;
					if (col_start == col_end)
						state <= pe_pkg::READ_IACT;   // empty column
					else
						state <= pe_pkg::READ_WEIGHT;
				end
				pe_pkg::READ_WEIGHT: begin
					state <= pe_pkg::DO_MAC;
				end
				pe_pkg::DO_MAC: begin
					state      <= pe_pkg::WRITE_BACK;
					weight_idx <= weight_idx + 1'b1;
				end
				pe_pkg::WRITE_BACK: begin
					if (weight_idx == col_end)
						state <= pe_pkg::READ_IACT;
					else
						state <= pe_pkg::READ_WEIGHT;
				end
				default: state <= pe_pkg::IDLE;
			endcase
		end
	end

	// datapath registers
	always_ff @(posedge clock) begin
		if (state == pe_pkg::READ_IACT)
			iact_val <= iact_value;
		if (state == pe_pkg::DO_MAC) begin
			row_reg <= weight_row;
			if (weight_row == pe_pkg::psum_idx_t'(`PAD_ROW))
				product_reg <= '0;   // padding row
			else
				product_reg <= iact_val * weight_value;
		end
	end

endmodule

`default_nettype wire

// File: src/psum_spad.sv
// partial-sum register file
// single-cycle clear, one write port, separate combinational
// read ports for accumulation and for the drain
`timescale 1ns/1ns
`default_nettype none

`include "pe_defs.svh"

module psum_spad (
	input  wire                      clock,
	input  wire                      reset,
	input  wire                      clear,
	input  wire                      write_en,
	input  wire pe_pkg::psum_idx_t   write_idx,
	input  wire pe_pkg::psum_t       write_data,
	input  wire pe_pkg::psum_idx_t   acc_idx,
	output pe_pkg::psum_t            acc_data,
	input  wire pe_pkg::psum_idx_t   drain_idx,
	output pe_pkg::psum_t            drain_data
);

	pe_pkg::psum_t regs [`PSUM_DEPTH];

	// clear wins over a write in the same cycle
	always_ff @(posedge clock) begin
		if (reset || clear) begin
			for (int i = 0; i < `PSUM_DEPTH; i++)
				regs[i] <= '0;
		end else if (write_en) begin
			regs[write_idx] <= write_data;
		end
	end

	assign acc_data   = regs[acc_idx];     // read-modify-write in WRITE_BACK
	assign drain_data = regs[drain_idx];

endmodule

`default_nettype wire

// File: src/col_ptr_spad.sv
// weight column pointer store
// pointer k marks the end of column k, so a column spans
// [ptr k-1, ptr k) with column 0 starting at zero
`timescale 1ns/1ns
`default_nettype none

`include "pe_defs.svh"

module col_ptr_spad (
	input  wire                      clock,
	input  wire                      reset,
	input  wire                      load_en,
	input  wire                      data_in_valid,
	input  wire  [`PTR_W-1:0]        data_in,
	output logic                     write_fin,
	input  wire  [`IACT_COL_W-1:0]   col,
	output logic [`PTR_W-1:0]        col_start,
	output logic [`PTR_W-1:0]        col_end
);

	localparam int AW = $clog2(`COL_COUNT);

	logic [`PTR_W-1:0] mem [`COL_COUNT];
	logic [AW-1:0]     wr_ptr;
	logic              loaded;
	logic              beat;
	logic              last_beat;

	assign beat      = load_en && data_in_valid && !loaded;
	assign last_beat = beat && (wr_ptr == AW'(`COL_COUNT - 1));   // 32nd pointer

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr    <= '0;
			loaded    <= 1'b0;
			write_fin <= 1'b0;
		end else begin
			write_fin <= last_beat;
			if (!load_en) begin
				wr_ptr <= '0;
				loaded <= 1'b0;
			end else if (beat) begin
				wr_ptr <= wr_ptr + 1'b1;
				loaded <= last_beat;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (beat)
			mem[wr_ptr] <= data_in;
	end

	assign col_start = (col == '0) ? '0 : mem[col - 1'b1];
	assign col_end   = mem[col];

endmodule

`default_nettype wire

// File: src/compressed_spad.sv
// compressed scratchpad for value/index entries
// loaded one beat per valid until an entry with a zero value field,
// which is stored too and ends the load; read port is registered
`timescale 1ns/1ns
`default_nettype none

`include "pe_defs.svh"

module compressed_spad #(
	parameter int ENTRY_W = 13,
	parameter int DEPTH   = 32
) (
	input  wire                clock,
	input  wire                reset,
	input  wire                load_en,
	input  wire                data_in_valid,
	input  wire  [ENTRY_W-1:0] data_in,
	output logic               write_fin,
	input  wire  [`PTR_W-1:0]  read_idx,
	output logic [ENTRY_W-1:0] data_out
);

	localparam int AW = $clog2(DEPTH);

	logic [ENTRY_W-1:0] mem [DEPTH];
	logic [AW-1:0]      wr_ptr;
	logic               loaded;     // terminator taken, ignore the rest
	logic               beat;
	logic               last_beat;

	assign beat      = load_en && data_in_valid && !loaded;
	assign last_beat = beat && (data_in[ENTRY_W-1 -: `VALUE_W] == '0);

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr    <= '0;
			loaded    <= 1'b0;
			write_fin <= 1'b0;
		end else begin
			write_fin <= last_beat;   // one cycle after the final beat
			if (!load_en) begin
				wr_ptr <= '0;
				loaded <= 1'b0;
			end else if (beat) begin
				wr_ptr <= wr_ptr + 1'b1;
				loaded <= last_beat;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (beat)
			mem[wr_ptr] <= data_in;
		data_out <= mem[read_idx[AW-1:0]];
	end

endmodule

`default_nettype wire

// File: src/pe_pkg.sv
// processing element types
// sequencer states and the partial-sum types used across the core
`default_nettype none

`include "pe_defs.svh"

package pe_pkg;

	// mac sequencer states, one weight entry takes READ_WEIGHT..WRITE_BACK
	typedef enum logic [2:0] {
		IDLE,
		READ_IACT,     // activation entry valid, check for terminator
		READ_PTR,      // column start and end looked up
		READ_WEIGHT,   // registered weight read issued
		DO_MAC,        // product registered
		WRITE_BACK     // psum + product written
	} seq_state_e;

	// signed partial sum
	typedef logic signed [`PSUM_W-1:0] psum_t;

	// index into the partial-sum scratchpad
	typedef logic [$clog2(`PSUM_DEPTH)-1:0] psum_idx_t;

endpackage

`default_nettype wire

// File: src/pe_defs.svh
// processing element widths and depths
// shared by the scratchpads, the sequencer and the drain path
`ifndef PE_DEFS_SVH
`define PE_DEFS_SVH

`define VALUE_W         8     // signed activation or weight value
`define PSUM_W          21    // signed partial sum

// activation entry is {value, weight column}
`define IACT_ENTRY_W    13
`define IACT_COL_W      5

// weight entry is {value, output row}
`define WEIGHT_ENTRY_W  12
`define WEIGHT_ROW_W    4

`define IACT_DEPTH      32
`define WEIGHT_DEPTH    128
`define COL_COUNT       32
`define PTR_W           7     // column pointer, also the scratchpad read index
`define PSUM_DEPTH      16
`define PAD_ROW         15    // padding row, product forced to zero

`endif
